//--- Bender.yml
package:
  name: ss_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/ss_map_pkg.sv
      - source/ss_host_pkg.sv
      - source/ss_load_fifo.sv
      - source/ss_save_buffer.sv
      - source/save_state_controller.sv
      - source/ss_subsystem_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/ss_clock_gen.sv
      - bench/ss_checker.sv
      - bench/tb_ss_subsystem.sv

//--- bench/ss_checker.sv
`default_nettype none

module ss_checker (
  input wire                          clk_sys,
  input wire                          reset,
  input wire                          start_req,
  input wire                          load_req,
  input wire ss_host_pkg::hs_status_t start_status,
  input wire ss_host_pkg::hs_status_t load_status,
  input wire ss_map_pkg::ss_bus_t     core_bus,
  input wire                          ss_halt,
  input wire                          ss_begin_reset,
  input wire                          ss_turbo,
  input wire                          push,
  input wire                          buffer_free
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // Outputs still hold their reset values on the first cycle out of reset
  a_reset_state: assert property (@(posedge clk_sys)
    $fell(reset) |-> core_bus.reset && !core_bus.wren && !ss_halt &&
                     !ss_begin_reset && !ss_turbo &&
                     start_status == '0 && load_status == '0)
    else begin
      $error("outputs not in reset state after reset");
      fail_count++;
    end

  // Core reset line released once idle is reached
  a_reset_release: assert property (@(posedge clk_sys)
    $fell(reset) |=> !core_bus.reset)
    else begin
      $error("core reset line did not fall after reset");
      fail_count++;
    end

  a_start_ack_rise: assert property (@(posedge clk_sys) disable iff (reset)
    $rose(start_status.ack) |-> start_req)
    else begin
      $error("start ack rose without a request");
      fail_count++;
    end

  a_start_ack_fall: assert property (@(posedge clk_sys) disable iff (reset)
    $fell(start_status.ack) |-> !$past(start_req))
    else begin
      $error("start ack fell while request was still high");
      fail_count++;
    end

  a_load_ack_rise: assert property (@(posedge clk_sys) disable iff (reset)
    $rose(load_status.ack) |-> load_req)
    else begin
      $error("load ack rose without a request");
      fail_count++;
    end

  a_load_ack_fall: assert property (@(posedge clk_sys) disable iff (reset)
    $fell(load_status.ack) |-> !$past(load_req))
    else begin
      $error("load ack fell while request was still high");
      fail_count++;
    end

  a_busy_ack: assert property (@(posedge clk_sys) disable iff (reset)
    !(start_status.ack && start_status.busy) && !(load_status.ack && load_status.busy))
    else begin
      $error("busy and ack high together");
      fail_count++;
    end

  // Error bits exist on the interface but are never raised
  a_no_err: assert property (@(posedge clk_sys) disable iff (reset)
    !start_status.err && !load_status.err)
    else begin
      $error("error status bit set");
      fail_count++;
    end

  // Push only into an empty buffer of a halted core
  a_push: assert property (@(posedge clk_sys) disable iff (reset)
    push |-> ss_halt && buffer_free)
    else begin
      $error("push while core running or buffer full");
      fail_count++;
    end

  a_wren: assert property (@(posedge clk_sys) disable iff (reset)
    core_bus.wren |-> ss_halt)
    else begin
      $error("core write while core not halted");
      fail_count++;
    end

  a_turbo_halt: assert property (@(posedge clk_sys) disable iff (reset)
    $fell(ss_turbo) |-> $rose(ss_halt))
    else begin
      $error("turbo dropped without halting the core");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- bench/ss_clock_gen.sv
`default_nettype none

module ss_clock_gen (
  output logic clk_sys,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;
  end

  // Reset held for 8 rising edges
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk_sys);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/tb_ss_subsystem.sv
`default_nettype none

`include "ss_defines.svh"

module tb_ss_subsystem;
  timeunit 1ns;
  timeprecision 100ps;

  import ss_host_pkg::*;
  import ss_map_pkg::*;

  localparam int word_count = `SS_WORD_COUNT;
  localparam int max_gap = 20;
  // Slowest sequence is a save with random read gaps
  localparam int longest_cycles = word_count * (`SS_READ_WAIT + max_gap + 6);
  // Four times the slowest sequence
  localparam time watchdog_ns = 4 * longest_cycles * 20;
  localparam logic [31:0] load_window = 32'(`SS_LOAD_BASE) << 28;
  localparam logic [31:0] save_window = 32'(`SS_SAVE_BASE) << 28;

  logic        clk_sys;
  logic        reset;
  bridge_t     bridge;
  logic        start_req;
  logic        load_req;
  logic [31:0] core_rdata;
  logic        ss_ready;
  logic [31:0] read_data;
  hs_status_t  start_status;
  hs_status_t  load_status;
  ss_bus_t     core_bus;
  logic        ss_halt;
  logic        ss_begin_reset;
  logic        ss_turbo;

  logic [31:0] core_regs [word_count];
  logic [31:0] new_words [word_count];
  int          seed = 89;
  int          data_errors = 0;
  int          total_errors;
  bit          turbo_seen = 0;
  bit          begin_reset_seen = 0;

  ss_clock_gen u_clock_gen (
    .clk_sys (clk_sys),
    .reset   (reset)
  );

  ss_subsystem_top u_dut (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .bridge         (bridge),
    .start_req      (start_req),
    .load_req       (load_req),
    .core_rdata     (core_rdata),
    .ss_ready       (ss_ready),
    .read_data      (read_data),
    .start_status   (start_status),
    .load_status    (load_status),
    .core_bus       (core_bus),
    .ss_halt        (ss_halt),
    .ss_begin_reset (ss_begin_reset),
    .ss_turbo       (ss_turbo)
  );

  bind ss_subsystem_top ss_checker u_checker (.*);

  // Core register model
  assign core_rdata = core_regs[core_bus.addr[3:0]];

  always @(posedge clk_sys) begin
    if (core_bus.wren) begin
      assert (core_bus.addr < word_count) else begin
        $display("core write to address %0d beyond the last register word", core_bus.addr);
        data_errors++;
      end
      core_regs[core_bus.addr[3:0]] <= core_bus.wdata;
    end
  end

  always @(negedge clk_sys) begin
    if (ss_turbo) begin
      turbo_seen = 1;
    end
    if (ss_begin_reset) begin
      begin_reset_seen = 1;
    end
  end

  // Lowest nibble of the word becomes the highest one
  function automatic logic [31:0] reverse_nibbles(input logic [31:0] word);
    return {word[3:0], word[7:4], word[11:8], word[15:12],
            word[19:16], word[23:20], word[27:24], word[31:28]};
  endfunction

  function automatic int random_below(input int limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      data_errors++;
    end
  endtask

  // Core becomes haltable a short random time later
  task automatic ready_after_request();
    int delay;
    delay = 1 + random_below(8);
    do @(negedge clk_sys); while (ss_halt);
    repeat (delay) @(posedge clk_sys);
    ss_ready <= 1'b1;
    do @(negedge clk_sys); while (!ss_halt);
    @(posedge clk_sys);
    ss_ready <= 1'b0;
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_sys);
    bridge <= '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
    @(posedge clk_sys);
    bridge <= '0;
  endtask

  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk_sys);
    bridge <= '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
    @(posedge clk_sys);
    bridge <= '0;
    @(negedge clk_sys);
    data = read_data;
  endtask

  task automatic run_start_request();
    @(posedge clk_sys);
    start_req <= 1'b1;
    fork
      ready_after_request();
    join_none
    do @(negedge clk_sys); while (!start_status.ack);
    @(posedge clk_sys);
    start_req <= 1'b0;
    do @(negedge clk_sys); while (start_status.ack);
    do @(negedge clk_sys); while (!start_status.ok);
  endtask

  task automatic read_save_state(input string name, input int gap_limit);
    logic [31:0] got;
    for (int i = 0; i < word_count; i++) begin
      repeat (random_below(gap_limit + 1)) @(posedge clk_sys);
      // Poll until the buffer holds the next word
      do @(negedge clk_sys); while (u_dut.buffer_free);
      bridge_read(save_window + 32'(4 * i), got);
      check_word($sformatf("%s word %0d", name, i), reverse_nibbles(core_regs[i]), got);
    end
  endtask

  task automatic write_load_state();
    int i;
    int burst;
    i = 0;
    fork
      begin
        do @(negedge clk_sys); while (!ss_turbo);
        ready_after_request();
      end
    join_none
    while (i < word_count) begin
      burst = 1 + random_below(`SS_FIFO_DEPTH);
      for (int b = 0; b < burst && i < word_count; b++) begin
        new_words[i] = $random(seed);
        bridge_write(load_window + 32'(4 * i), new_words[i]);
        i++;
      end
      do @(negedge clk_sys); while (!u_dut.fifo_empty);
      repeat (random_below(6)) @(posedge clk_sys);
    end
  endtask

  task automatic run_load_request();
    @(posedge clk_sys);
    load_req <= 1'b1;
    do @(negedge clk_sys); while (!load_status.ack);
    assert (!start_status.ok) else begin
      $display("start ok still high after the load request began");
      data_errors++;
    end
    @(posedge clk_sys);
    load_req <= 1'b0;
    do @(negedge clk_sys); while (load_status.ack);
    do @(negedge clk_sys); while (!load_status.ok);
    assert (begin_reset_seen) else begin
      $display("core reset was not pulsed before load ok");
      data_errors++;
    end
    assert (turbo_seen) else begin
      $display("turbo never rose during the load");
      data_errors++;
    end
  endtask

  initial begin
    bridge    = '0;
    start_req = 1'b0;
    load_req  = 1'b0;
    ss_ready  = 1'b0;
    for (int i = 0; i < word_count; i++) begin
      core_regs[i] = $random(seed);
    end
    do @(negedge clk_sys); while (reset);
    repeat (4) @(posedge clk_sys);

    run_start_request();
    read_save_state("save", 0);
    run_start_request();
    read_save_state("save backpressure", max_gap);

    write_load_state();
    run_load_request();
    for (int i = 0; i < word_count; i++) begin
      check_word($sformatf("load word %0d", i), reverse_nibbles(new_words[i]), core_regs[i]);
    end

    repeat (5) @(posedge clk_sys);
    total_errors = data_errors + u_dut.u_checker.fail_count;
    $display("Data errors: %0d, assertion errors: %0d", data_errors,
             u_dut.u_checker.fail_count);
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/save_state_controller.sv
`default_nettype none

`include "ss_defines.svh"

module save_state_controller (
  input  wire                     clk_sys,
  input  wire                     reset,
  input  wire                     start_req,
  input  wire                     load_req,
  input  wire                     fifo_empty,
  input  wire              [31:0] fifo_data,
  input  wire                     buffer_free,
  input  wire                     ss_ready,
  output ss_host_pkg::hs_status_t start_status,
  output ss_host_pkg::hs_status_t load_status,
  output logic                    pop,
  output logic                    push,
  output ss_map_pkg::ss_bus_t     core_bus,
  output logic                    ss_halt,
  output logic                    ss_begin_reset,
  output logic                    ss_turbo
);
  import ss_map_pkg::*;

  localparam int hs_w = $clog2(`SS_HS_DELAY + 1);
  localparam int read_cnt_w = $clog2(`SS_READ_WAIT + 1);
  localparam logic [hs_w-1:0] hs_reload = hs_w'(`SS_HS_DELAY - 1);
  localparam logic [read_cnt_w-1:0] wait_last = read_cnt_w'(`SS_READ_WAIT - 1);
  localparam logic [read_cnt_w-1:0] wait_done = read_cnt_w'(`SS_READ_WAIT);
  localparam ss_addr_t last_addr = ss_addr_t'(`SS_WORD_COUNT - 1);

  typedef enum logic [3:0] {
    st_idle,
    st_save_ack,
    st_save_wait_ready,
    st_save_data,
    st_save_wait_buf,
    st_load_data,
    st_load_write,
    st_load_ack,
    st_load_busy
  } state_t;

  state_t                state;
  logic [hs_w-1:0]       hs_delay;
  logic [read_cnt_w-1:0] read_cnt;
  logic                  halt_when_possible;
  ss_addr_t              bus_addr;
  logic                  bus_wren;
  logic                  bus_reset;

  // Load data goes straight from the FIFO output onto the bus
  assign core_bus = '{addr: bus_addr, wren: bus_wren, reset: bus_reset, wdata: fifo_data};

  // Core runs fast until it reaches a point where it can be halted
  assign ss_turbo = halt_when_possible;

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      state              <= st_idle;
      hs_delay           <= '0;
      read_cnt           <= '0;
      halt_when_possible <= 1'b0;
      bus_addr           <= '0;
      bus_wren           <= 1'b0;
      bus_reset          <= 1'b1;
      pop                <= 1'b0;
      push               <= 1'b0;
      ss_halt            <= 1'b0;
      ss_begin_reset     <= 1'b0;
      start_status       <= '0;
      load_status        <= '0;
    end else begin
      if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end

      if (halt_when_possible && ss_ready) begin
        halt_when_possible <= 1'b0;
        ss_halt            <= 1'b1;
      end

      case (state)
        st_idle: begin
          bus_reset <= 1'b0;
          bus_addr  <= '0;
          if (start_req) begin
            state           <= st_save_ack;
            hs_delay        <= hs_reload;
            ss_halt         <= 1'b0;
            start_status    <= '0;
            load_status.ok  <= 1'b0;
            load_status.err <= 1'b0;
          end else if (!fifo_empty) begin
            // First load word has arrived
            state              <= st_load_data;
            bus_addr           <= '1;
            ss_halt            <= 1'b0;
            halt_when_possible <= 1'b1;
          end
        end

        st_save_ack: begin
          if (!start_status.ack) begin
            if (hs_delay == '0) begin
              start_status.ack <= 1'b1;
              hs_delay         <= hs_reload;
            end
          end else if (!start_req && hs_delay == '0) begin
            start_status.ack  <= 1'b0;
            start_status.busy <= 1'b1;
            state             <= st_save_wait_ready;
          end
        end

        st_save_wait_ready: begin
          if (ss_ready) begin
            state             <= st_save_data;
            bus_addr          <= '0;
            read_cnt          <= '0;
            ss_halt           <= 1'b1;
            start_status.busy <= 1'b0;
            start_status.ok   <= 1'b1;
          end
        end

        st_save_data: begin
          if (read_cnt == wait_last) begin
            // Core word is stable now, hand it over if the host took the last one
            if (buffer_free) begin
              push     <= 1'b1;
              read_cnt <= wait_done;
            end else begin
              state <= st_save_wait_buf;
            end
          end else if (read_cnt == wait_done) begin
            push     <= 1'b0;
            read_cnt <= '0;
            bus_addr <= bus_addr + 1'b1;
            if (bus_addr == last_addr) begin
              state <= st_idle;
            end
          end else begin
            read_cnt <= read_cnt + 1'b1;
          end
        end

        st_save_wait_buf: begin
          // Host is slow, hold the word until the buffer empties
          if (buffer_free) begin
            push     <= 1'b1;
            read_cnt <= wait_done;
            state    <= st_save_data;
          end
        end

        st_load_data: begin
          bus_wren <= 1'b0;
          if (bus_addr == last_addr) begin
            state <= st_load_ack;
          end else if (!fifo_empty && ss_halt) begin
            pop   <= 1'b1;
            state <= st_load_write;
          end
        end

        st_load_write: begin
          // FIFO word is on fifo_data in the cycle wren is high
          pop      <= 1'b0;
          bus_wren <= 1'b1;
          bus_addr <= bus_addr + 1'b1;
          state    <= st_load_data;
        end

        st_load_ack: begin
          if (!ss_begin_reset) begin
            if (load_req) begin
              ss_begin_reset   <= 1'b1;
              hs_delay         <= hs_reload;
              load_status      <= '0;
              start_status.ok  <= 1'b0;
              start_status.err <= 1'b0;
            end
          end else if (!load_status.ack) begin
            if (hs_delay == '0) begin
              load_status.ack <= 1'b1;
              hs_delay        <= hs_reload;
            end
          end else if (!load_req && hs_delay == '0) begin
            load_status.ack  <= 1'b0;
            load_status.busy <= 1'b1;
            hs_delay         <= hs_reload;
            state            <= st_load_busy;
          end
        end

        st_load_busy: begin
          // Core leaves halt through its reset
          if (hs_delay == '0) begin
            load_status.busy <= 1'b0;
            load_status.ok   <= 1'b1;
            ss_begin_reset   <= 1'b0;
            ss_halt          <= 1'b0;
            state            <= st_idle;
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/ss_defines.svh
`ifndef SS_DEFINES_SVH
`define SS_DEFINES_SVH

// Register words that make up one save state
`define SS_WORD_COUNT 16

// Top address nibble of the bridge window used for loading
`define SS_LOAD_BASE 4

// Top address nibble of the bridge window used for saving
`define SS_SAVE_BASE 4

// Entries in the load FIFO
`define SS_FIFO_DEPTH 4

// Cycles the core needs to present a read word
`define SS_READ_WAIT 10

// Cycles between two handshake phases
`define SS_HS_DELAY 3

`endif

//--- source/ss_host_pkg.sv
`default_nettype none

package ss_host_pkg;

  // One bridge cycle, wr and rd are single cycle strobes
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bridge_t;

  // Status returned to the host for one request
  typedef struct packed {
    logic ack;
    logic busy;
    logic ok;
    logic err;
  } hs_status_t;

  // Bridge words are big-endian by nibble
  function automatic logic [31:0] nibble_swap(input logic [31:0] value);
    logic [31:0] swapped;
    for (int i = 0; i < 8; i++) begin
      swapped[4*i +: 4] = value[4*(7-i) +: 4];
    end
    return swapped;
  endfunction

endpackage

`default_nettype wire

//--- source/ss_load_fifo.sv
`default_nettype none

`include "ss_defines.svh"

module ss_load_fifo (
  input  wire                  clk_sys,
  input  wire                  reset,
  input  wire ss_host_pkg::bridge_t bridge,
  input  wire                  pop,
  output logic                 empty,
  output logic          [31:0] fifo_data
);
  import ss_host_pkg::*;

  localparam int depth = `SS_FIFO_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  logic [31:0]      mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             in_window;
  logic             wr_en;
  logic             rd_en;

  // Pointer wrap that also works for depths that are not a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Byte addressed window, one entry per register word
  assign in_window = (bridge.addr[31:28] == 4'(`SS_LOAD_BASE)) &&
                     (bridge.addr[27:2] < 26'(`SS_WORD_COUNT));

  // Writes into a full FIFO are lost
  assign wr_en = bridge.wr && in_window && (count != cnt_w'(depth));
  assign rd_en = pop && (count != '0);
  assign empty = (count == '0);

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and output word
  always_ff @(posedge clk_sys) begin
    if (wr_en) begin
      mem[wr_ptr] <= bridge.wdata;
    end
    if (rd_en) begin
      fifo_data <= nibble_swap(mem[rd_ptr]);
    end
  end

endmodule

`default_nettype wire

//--- source/ss_map_pkg.sv
`default_nettype none

package ss_map_pkg;

  // Word address of a core register
  typedef logic [7:0] ss_addr_t;

  // Bus from the controller into the core registers
  typedef struct packed {
    // Register word being accessed
    ss_addr_t    addr;
    // One cycle write strobe
    logic        wren;
    // Puts every register back to its default
    logic        reset;
    // Word to be written, already in core order
    logic [31:0] wdata;
  } ss_bus_t;

endpackage

`default_nettype wire

//--- source/ss_save_buffer.sv
`default_nettype none

`include "ss_defines.svh"

module ss_save_buffer (
  input  wire                  clk_sys,
  input  wire                  reset,
  input  wire ss_host_pkg::bridge_t bridge,
  input  wire                  push,
  input  wire           [31:0] core_rdata,
  output logic                 free,
  output logic          [31:0] read_data
);
  import ss_host_pkg::*;

  logic [31:0] held_word;
  logic        full;
  logic        rd_hit;

  // Host read of the save window
  assign rd_hit = bridge.rd &&
                  (bridge.addr[31:28] == 4'(`SS_SAVE_BASE)) &&
                  (bridge.addr[27:2] < 26'(`SS_WORD_COUNT));

  assign free = ~full;

  // A push only comes while free, so it can never meet a pending word
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      full <= 1'b0;
    end else if (push) begin
      full <= 1'b1;
    end else if (rd_hit) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (push) begin
      held_word <= core_rdata;
    end
    // Nothing held yet reads back as zero
    if (rd_hit) begin
      read_data <= full ? nibble_swap(held_word) : '0;
    end
  end

endmodule

`default_nettype wire

//--- source/ss_subsystem_top.sv
`default_nettype none

module ss_subsystem_top (
  input  wire                          clk_sys,
  input  wire                          reset,
  input  wire ss_host_pkg::bridge_t    bridge,
  input  wire                          start_req,
  input  wire                          load_req,
  input  wire                   [31:0] core_rdata,
  input  wire                          ss_ready,
  output wire                   [31:0] read_data,
  output wire ss_host_pkg::hs_status_t start_status,
  output wire ss_host_pkg::hs_status_t load_status,
  output wire ss_map_pkg::ss_bus_t     core_bus,
  output wire                          ss_halt,
  output wire                          ss_begin_reset,
  output wire                          ss_turbo
);

  wire        fifo_empty;
  wire [31:0] fifo_data;
  wire        pop;
  wire        push;
  wire        buffer_free;

  // Host writes on their way into the core
  ss_load_fifo u_load_fifo (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .bridge    (bridge),
    .pop       (pop),
    .empty     (fifo_empty),
    .fifo_data (fifo_data)
  );

  // Core words on their way out to the host
  ss_save_buffer u_save_buffer (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .bridge     (bridge),
    .push       (push),
    .core_rdata (core_rdata),
    .free       (buffer_free),
    .read_data  (read_data)
  );

  save_state_controller u_controller (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .start_req      (start_req),
    .load_req       (load_req),
    .fifo_empty     (fifo_empty),
    .fifo_data      (fifo_data),
    .buffer_free    (buffer_free),
    .ss_ready       (ss_ready),
    .start_status   (start_status),
    .load_status    (load_status),
    .pop            (pop),
    .push           (push),
    .core_bus       (core_bus),
    .ss_halt        (ss_halt),
    .ss_begin_reset (ss_begin_reset),
    .ss_turbo       (ss_turbo)
  );

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/ss_map_pkg.sv
source/ss_host_pkg.sv
source/ss_load_fifo.sv
source/ss_save_buffer.sv
source/save_state_controller.sv
source/ss_subsystem_top.sv
bench/ss_clock_gen.sv
bench/ss_checker.sv
bench/tb_ss_subsystem.sv
